// File: include/tb_tlb_model.svh
`ifndef TB_TLB_MODEL_SVH
`define TB_TLB_MODEL_SVH

// Shadow copy of the entry array
tlb_pkg::tlb_entry_t mdl [tlb_pkg::TLB_NUM];

function automatic logic model_match(tlb_pkg::tlb_entry_t ent, tlb_pkg::asid_t asid,
                                     tlb_pkg::vppn_t vppn, logic by_size);
    logic huge;
    logic vppn_ok;
    huge    = by_size && (ent.ps != 6'd12);
    vppn_ok = huge ? (ent.vppn[18:9] == vppn[18:9]) : (ent.vppn == vppn);
    return ent.e && (ent.g || ent.asid == asid) && vppn_ok;
endfunction

function automatic tlb_pkg::xlate_rsp_t model_xlate(tlb_pkg::vaddr_t va,
                                                    tlb_pkg::csr_view_t c, logic dac);
    tlb_pkg::xlate_rsp_t r;
    tlb_pkg::tlb_entry_t ent;
    tlb_pkg::tlb_page_t  pg;
    logic                hit;
    logic                huge;
    r       = '0;
    ent     = '0;
    hit     = 1'b0;
    r.valid = 1'b1;
    if (!c.pg) begin
        r.pa     = va;
        r.cached = dac;
    end else if (c.dmw0.en && c.dmw0.vseg == va[31:29]) begin
        r.pa     = {c.dmw0.pseg, va[28:0]};
        r.cached = c.dmw0.cached;
    end else if (c.dmw1.en && c.dmw1.vseg == va[31:29]) begin
        r.pa     = {c.dmw1.pseg, va[28:0]};
        r.cached = c.dmw1.cached;
    end else begin
        r.mapped = 1'b1;
        for (int i = tlb_pkg::TLB_NUM - 1; i >= 0; i--) begin
            if (model_match(mdl[i], c.asid, va[31:13], 1'b1)) begin
                ent = mdl[i];
                hit = 1'b1;
            end
        end
        huge = ent.ps != 6'd12;
        pg   = (huge ? va[21] : va[12]) ? ent.odd : ent.even;
        if (hit) begin
            r.hit        = 1'b1;
            r.page_valid = pg.v;
            r.dirty      = pg.d;
            r.plv        = pg.plv;
            r.cached     = pg.mat == 2'd1;
            if (pg.v) begin
                r.pa = huge ? {pg.ppn[19:9], va[20:0]} : {pg.ppn, va[11:0]};
            end
        end
    end
    return r;
endfunction

function automatic logic model_inv_kill(tlb_pkg::tlb_entry_t ent, int op,
                                        tlb_pkg::asid_t asid, tlb_pkg::vppn_t vppn);
    case (op)
        0, 1: return 1'b1;
        2: return ent.g;
        3: return !ent.g;
        4: return !ent.g && ent.asid == asid;
        5: return !ent.g && ent.asid == asid && ent.vppn == vppn;
        6: return (ent.g || ent.asid != asid) && ent.vppn == vppn;
        default: return 1'b0;
    endcase
endfunction

`endif

// File: bench/tb_tlb.sv
module tb_tlb;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk = 1'b0;
    logic rstn;
    tlb_pkg::csr_view_t  csr;
    logic                flush, fetch_stall, data_stall;
    tlb_pkg::xlate_req_t fetch_req, data_req;
    tlb_pkg::xlate_rsp_t fetch_rsp, data_rsp;
    logic                wr_strobe, rd_strobe, srch_strobe, inv_strobe;
    tlb_pkg::tlb_entry_t wr_entry, rd_entry;
    tlb_pkg::tlb_idx_t   rd_index, srch_index;
    logic                rd_done, rd_hit, srch_done, srch_hit;
    tlb_pkg::inv_op_t    inv_op;
    tlb_pkg::asid_t      inv_asid;
    tlb_pkg::vppn_t      inv_vppn;
    logic [31:0]         lfsr = 32'd71243;
    int                  errors = 0;
    int                  test_start = 0;
    int                  n_pass = 0;
    int                  n_fail = 0;

    `include "tb_tlb_model.svh"

    tlb_top i_dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] rnd(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD0000001) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Small pools so that duplicate matches show up
    function automatic tlb_pkg::vppn_t pool_vppn();
        return {8'd0, 2'(rnd(2)), 1'(rnd(1)), 6'd0, 2'(rnd(2))};
    endfunction

    function automatic tlb_pkg::tlb_entry_t rand_entry();
        tlb_pkg::tlb_entry_t ent;
        ent.e    = rnd(2) != 0;
        ent.asid = tlb_pkg::asid_t'(rnd(2));
        ent.g    = rnd(2) == 0;
        ent.ps   = (rnd(1) != 0) ? 6'd12 : 6'd21;
        ent.vppn = pool_vppn();
        ent.even = tlb_pkg::tlb_page_t'(rnd(26));
        ent.odd  = tlb_pkg::tlb_page_t'(rnd(26));
        return ent;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(string name, logic [127:0] exp, logic [127:0] act);
        if (exp !== act) begin
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(string name);
        $display("%s: %s (%0d errors)", name, (errors == test_start) ? "passed" : "failed",
                 errors - test_start);
        if (errors == test_start) n_pass++;
        else n_fail++;
        test_start = errors;
    endtask

    task automatic write_entry(int idx, tlb_pkg::tlb_entry_t ent);
        csr.wr_index = tlb_pkg::tlb_idx_t'(idx);
        wr_entry     = ent;
        wr_strobe    = 1'b1;
        tick();
        wr_strobe = 1'b0;
        mdl[idx]  = ent;
    endtask

    task automatic fill_random();
        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) write_entry(i, rand_entry());
    endtask

    task automatic translate_pair(tlb_pkg::vaddr_t va_f, tlb_pkg::vaddr_t va_d, int stall_cyc);
        tlb_pkg::xlate_rsp_t exp_f;
        tlb_pkg::xlate_rsp_t exp_d;
        int n;
        exp_f = model_xlate(va_f, csr, csr.da_cached_fetch);
        exp_d = model_xlate(va_d, csr, csr.da_cached_data);
        fetch_req = {1'b1, va_f};
        data_req  = {1'b1, va_d};
        tick();
        fetch_req.valid = 1'b0;
        data_req.valid  = 1'b0;
        fetch_stall = stall_cyc > 0;
        data_stall  = stall_cyc > 0;
        for (int i = 0; i < stall_cyc; i++) begin
            tick();
            check_value("fetch_rsp.valid in stall", 128'(0), 128'(fetch_rsp.valid));
        end
        fetch_stall = 1'b0;
        data_stall  = 1'b0;
        n = 0;
        while (!fetch_rsp.valid && n < 20) begin
            tick();
            n++;
        end
        if (!fetch_rsp.valid) begin
            $display("fetch response never became valid within 20 cycles");
            errors++;
        end
        check_value("latency", 128'(stall_cyc + 2), 128'(stall_cyc + n + 1));
        check_value("fetch_rsp", 128'(exp_f), 128'(fetch_rsp));
        check_value("data_rsp", 128'(exp_d), 128'(data_rsp));
        // Response must hold under stall
        fetch_stall = 1'b1;
        data_stall  = 1'b1;
        tick();
        check_value("fetch_rsp held", 128'(exp_f), 128'(fetch_rsp));
        check_value("data_rsp held", 128'(exp_d), 128'(data_rsp));
        fetch_stall = 1'b0;
        data_stall  = 1'b0;
    endtask

    task automatic flush_check(tlb_pkg::vaddr_t va);
        data_req = {1'b1, va};
        tick();
        data_req.valid = 1'b0;
        // Flush has to override a stall in the same cycle
        flush      = 1'b1;
        data_stall = 1'b1;
        tick();
        flush      = 1'b0;
        data_stall = 1'b0;
        for (int i = 0; i < 4; i++) begin
            check_value("data_rsp.valid after flush", 128'(0), 128'(data_rsp.valid));
            tick();
        end
    endtask

    task automatic search_check();
        logic hit;
        int   idx;
        hit = 1'b0;
        idx = 0;
        csr.asid      = tlb_pkg::asid_t'(rnd(2));
        csr.srch_vppn = pool_vppn();
        for (int i = tlb_pkg::TLB_NUM - 1; i >= 0; i--) begin
            if (model_match(mdl[i], csr.asid, csr.srch_vppn, 1'b0)) begin
                hit = 1'b1;
                idx = i;
            end
        end
        srch_strobe = 1'b1;
        tick();
        srch_strobe = 1'b0;
        for (int n = 0; n < 20 && !srch_done; n++) tick();
        if (!srch_done) begin
            $display("search done pulse did not arrive within 20 cycles");
            errors++;
        end
        check_value("srch_hit", 128'(hit), 128'(srch_hit));
        check_value("srch_index", 128'(idx), 128'(srch_index));
        tick();
        check_value("srch_done after pulse", 128'(0), 128'(srch_done));
    endtask

    task automatic read_check(int idx);
        rd_index  = tlb_pkg::tlb_idx_t'(idx);
        rd_strobe = 1'b1;
        tick();
        rd_strobe = 1'b0;
        for (int n = 0; n < 20 && !rd_done; n++) tick();
        if (!rd_done) begin
            $display("read done pulse did not arrive within 20 cycles");
            errors++;
        end
        check_value("rd_entry", 128'(mdl[idx]), 128'(rd_entry));
        check_value("rd_hit", 128'(mdl[idx].e), 128'(rd_hit));
        tick();
        check_value("rd_done after pulse", 128'(0), 128'(rd_done));
    endtask

    task automatic invalidate(int op);
        inv_op     = tlb_pkg::inv_op_t'(op);
        inv_asid   = tlb_pkg::asid_t'(rnd(2));
        inv_vppn   = pool_vppn();
        inv_strobe = 1'b1;
        tick();
        inv_strobe = 1'b0;
        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
            if (model_inv_kill(mdl[i], op, inv_asid, inv_vppn)) mdl[i].e = 1'b0;
        end
    endtask

    initial begin
        rstn = 1'b0;
        csr = '0;
        flush = 1'b0;
        fetch_stall = 1'b0;
        data_stall = 1'b0;
        fetch_req = '0;
        data_req = '0;
        wr_strobe = 1'b0;
        wr_entry = '0;
        rd_strobe = 1'b0;
        rd_index = '0;
        srch_strobe = 1'b0;
        inv_strobe = 1'b0;
        inv_op = tlb_pkg::INV_ALL0;
        inv_asid = '0;
        inv_vppn = '0;
        for (int i = 0; i < tlb_pkg::TLB_NUM; i++) mdl[i] = '0;
        repeat (5) @(posedge clk);
        #1 rstn = 1'b1;
        tick();

        csr.da_cached_fetch = 1'(rnd(1));
        csr.da_cached_data  = 1'(rnd(1));
        for (int i = 0; i < 8; i++) translate_pair(rnd(32), rnd(32), 0);
        csr.pg        = 1'b1;
        csr.dmw0      = {1'b1, 7'(rnd(7))};
        csr.dmw1      = {1'b1, 7'(rnd(7))};
        csr.dmw1.vseg = csr.dmw0.vseg + 3'd1;
        // Offsets 0 and 1 land in the windows, 2 and 3 go to the TLB
        for (int i = 0; i < 16; i++) begin
            translate_pair({csr.dmw0.vseg + 3'(rnd(2)), 29'(rnd(29))},
                           {csr.dmw0.vseg + 3'(rnd(2)), 29'(rnd(29))}, 0);
        end
        // Both windows on one segment so dmw0 has to win
        csr.dmw1.vseg   = csr.dmw0.vseg;
        csr.dmw1.pseg   = ~csr.dmw0.pseg;
        csr.dmw1.cached = ~csr.dmw0.cached;
        for (int i = 0; i < 4; i++) begin
            translate_pair({csr.dmw0.vseg, 29'(rnd(29))}, {csr.dmw0.vseg, 29'(rnd(29))}, 0);
        end
        finish_test("direct_window");

        csr.dmw0.en = 1'b0;
        csr.dmw1.en = 1'b0;
        fill_random();
        for (int i = 0; i < 32; i++) begin
            csr.asid = tlb_pkg::asid_t'(rnd(2));
            translate_pair({pool_vppn(), 13'(rnd(13))}, {pool_vppn(), 13'(rnd(13))}, 0);
        end
        finish_test("mapped");

        for (int i = 0; i < 8; i++) begin
            translate_pair({pool_vppn(), 13'(rnd(13))}, {pool_vppn(), 13'(rnd(13))},
                           int'(rnd(2)) + 1);
        end
        for (int i = 0; i < 4; i++) flush_check({pool_vppn(), 13'(rnd(13))});
        finish_test("stall_flush");

        for (int i = 0; i < 24; i++) search_check();
        finish_test("search");

        for (int i = 0; i < 16; i++) write_entry(int'(rnd(5)), rand_entry());
        for (int i = 0; i < 16; i++) read_check(int'(rnd(5)));
        finish_test("write_read");

        for (int op = 0; op < 7; op++) begin
            fill_random();
            invalidate(op);
            for (int i = 0; i < tlb_pkg::TLB_NUM; i++) read_check(i);
            for (int i = 0; i < 4; i++) begin
                csr.asid = tlb_pkg::asid_t'(rnd(2));
                translate_pair({pool_vppn(), 13'(rnd(13))}, {pool_vppn(), 13'(rnd(13))}, 0);
            end
        end
        finish_test("invalidate");

        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/tlb_entry_array.sv
module tlb_entry_array (
    input  logic                                       clk,
    input  logic                                       rstn,

    input  logic                                       wr_strobe,
    input  tlb_pkg::tlb_idx_t                          wr_index,
    input  tlb_pkg::tlb_entry_t                        wr_entry,

    input  logic                                       inv_strobe,
    input  tlb_pkg::inv_op_t                           inv_op,
    input  tlb_pkg::asid_t                             inv_asid,
    input  tlb_pkg::vppn_t                             inv_vppn,

    input  logic                                       rd_strobe,
    input  tlb_pkg::tlb_idx_t                          rd_index,
    output logic                                       rd_done,
    output logic                                       rd_hit,
    output tlb_pkg::tlb_entry_t                        rd_entry,

    output tlb_pkg::tlb_entry_t [tlb_pkg::TLB_NUM-1:0] entries
);

    logic [tlb_pkg::TLB_NUM-1:0] asid_eq;
    logic [tlb_pkg::TLB_NUM-1:0] vppn_eq;

    for (genvar i = 0; i < tlb_pkg::TLB_NUM; i++) begin : g_cmp
        assign asid_eq[i] = entries[i].asid == inv_asid;
        assign vppn_eq[i] = entries[i].vppn == inv_vppn;
    end

    // Write has priority, invalidate only drops the exists bit
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            entries <= '0;
        end else if (wr_strobe) begin
            entries[wr_index] <= wr_entry;
        end else if (inv_strobe) begin
            for (int i = 0; i < tlb_pkg::TLB_NUM; i++) begin
                case (inv_op)
                    tlb_pkg::INV_ALL0,
                    tlb_pkg::INV_ALL1: begin
                        entries[i].e <= 1'b0;
                    end
                    tlb_pkg::INV_GLOBAL: begin
                        if (entries[i].g) begin
                            entries[i].e <= 1'b0;
                        end
                    end
                    tlb_pkg::INV_NONGLOBAL: begin
                        if (!entries[i].g) begin
                            entries[i].e <= 1'b0;
                        end
                    end
                    tlb_pkg::INV_ASID: begin
                        if (!entries[i].g && asid_eq[i]) begin
                            entries[i].e <= 1'b0;
                        end
                    end
                    tlb_pkg::INV_ASID_VA: begin
                        if (!entries[i].g && asid_eq[i] && vppn_eq[i]) begin
                            entries[i].e <= 1'b0;
                        end
                    end
                    tlb_pkg::INV_GORASID_VA: begin
                        if ((entries[i].g || !asid_eq[i]) && vppn_eq[i]) begin
                            entries[i].e <= 1'b0;
                        end
                    end
                    default: begin
                        // Unknown ops leave the array alone
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_done <= 1'b0;
            rd_hit  <= 1'b0;
        end else begin
            rd_done <= rd_strobe;
            if (rd_strobe) begin
                rd_hit <= entries[rd_index].e;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            rd_entry <= entries[rd_index];
        end
    end

endmodule

// File: rtl/tlb_lookup_lane.sv
module tlb_lookup_lane (
    input  logic                                       clk,
    input  logic                                       rstn,
    input  logic                                       flush,
    input  logic                                       stall,
    input  tlb_pkg::xlate_req_t                        req,
    input  tlb_pkg::csr_view_t                         csr,
    input  logic                                       da_cached,
    input  tlb_pkg::tlb_entry_t [tlb_pkg::TLB_NUM-1:0] entries,
    output tlb_pkg::xlate_rsp_t                        rsp
);

    tlb_pkg::vppn_t              req_vppn;
    logic [tlb_pkg::TLB_NUM-1:0] match;
    tlb_pkg::tlb_entry_t         sel_entry;
    logic                        sel_hit;

    logic                        s1_valid;
    tlb_pkg::vaddr_t             s1_va;
    logic                        s1_hit;
    logic                        s1_huge;
    tlb_pkg::tlb_page_t          s1_even;
    tlb_pkg::tlb_page_t          s1_odd;

    logic                        dmw0_hit;
    logic                        dmw1_hit;
    logic                        odd_sel;
    tlb_pkg::tlb_page_t          page;
    tlb_pkg::xlate_rsp_t         rsp_nxt;

    assign req_vppn = req.va[tlb_pkg::VA_W-1:tlb_pkg::SMALL_ODD_BIT+1];

    // Huge pages only compare VA bits 31..22
    for (genvar i = 0; i < tlb_pkg::TLB_NUM; i++) begin : g_match
        logic huge;
        logic vppn_eq;
        logic asid_ok;

        assign huge    = entries[i].ps != tlb_pkg::PS_4K;
        assign asid_ok = entries[i].g || (entries[i].asid == csr.asid);
        assign vppn_eq = huge
            ? (entries[i].vppn[tlb_pkg::VPPN_W-1:tlb_pkg::HUGE_ODD_BIT-tlb_pkg::SMALL_ODD_BIT]
               == req_vppn[tlb_pkg::VPPN_W-1:tlb_pkg::HUGE_ODD_BIT-tlb_pkg::SMALL_ODD_BIT])
            : (entries[i].vppn == req_vppn);
        assign match[i] = entries[i].e && asid_ok && vppn_eq;
    end

    // Lowest index wins
    always_comb begin
        sel_entry = '0;
        sel_hit   = 1'b0;
        for (int i = tlb_pkg::TLB_NUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel_entry = entries[i];
                sel_hit   = 1'b1;
            end
        end
    end

    assign dmw0_hit = csr.dmw0.en && (csr.dmw0.vseg == s1_va[tlb_pkg::VA_W-1:tlb_pkg::VA_W-3]);
    assign dmw1_hit = csr.dmw1.en && (csr.dmw1.vseg == s1_va[tlb_pkg::VA_W-1:tlb_pkg::VA_W-3]);
    assign odd_sel  = s1_huge ? s1_va[tlb_pkg::HUGE_ODD_BIT] : s1_va[tlb_pkg::SMALL_ODD_BIT];
    assign page     = odd_sel ? s1_odd : s1_even;

    always_comb begin
        rsp_nxt       = '0;
        rsp_nxt.valid = s1_valid;
        if (!csr.pg) begin
            rsp_nxt.pa     = s1_va;
            rsp_nxt.cached = da_cached;
        end else if (dmw0_hit) begin
            rsp_nxt.pa     = {csr.dmw0.pseg, s1_va[tlb_pkg::VA_W-4:0]};
            rsp_nxt.cached = csr.dmw0.cached;
        end else if (dmw1_hit) begin
            rsp_nxt.pa     = {csr.dmw1.pseg, s1_va[tlb_pkg::VA_W-4:0]};
            rsp_nxt.cached = csr.dmw1.cached;
        end else begin
            rsp_nxt.mapped     = 1'b1;
            rsp_nxt.hit        = s1_hit;
            rsp_nxt.page_valid = s1_hit && page.v;
            rsp_nxt.dirty      = s1_hit && page.d;
            rsp_nxt.plv        = s1_hit ? page.plv : 2'b00;
            rsp_nxt.cached     = s1_hit && (page.mat == tlb_pkg::MAT_CACHED);
            if (s1_hit && page.v) begin
                if (s1_huge) begin
                    rsp_nxt.pa = {page.ppn[tlb_pkg::PPN_W-1:tlb_pkg::HUGE_ODD_BIT-tlb_pkg::SMALL_ODD_BIT],
                                  s1_va[tlb_pkg::HUGE_ODD_BIT-1:0]};
                end else begin
                    rsp_nxt.pa = {page.ppn, s1_va[tlb_pkg::SMALL_ODD_BIT-1:0]};
                end
            end
        end
    end

    // Flush beats stall; stall freezes both stages
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            s1_va    <= '0;
            s1_hit   <= 1'b0;
            s1_huge  <= 1'b0;
            s1_even  <= '0;
            s1_odd   <= '0;
            rsp      <= '0;
        end else if (flush) begin
            s1_valid  <= 1'b0;
            rsp.valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= req.valid;
            s1_va    <= req.va;
            s1_hit   <= sel_hit;
            s1_huge  <= sel_entry.ps != tlb_pkg::PS_4K;
            s1_even  <= sel_entry.even;
            s1_odd   <= sel_entry.odd;
            rsp      <= rsp_nxt;
        end
    end

endmodule

// File: rtl/tlb_pkg.sv
package tlb_pkg;

    localparam int TLB_NUM = 32;
    localparam int IDX_W   = 5;
    localparam int VA_W    = 32;
    localparam int VPPN_W  = 19;
    localparam int PPN_W   = 20;
    localparam int ASID_W  = 10;
    localparam int PS_W    = 6;

    localparam logic [PS_W-1:0] PS_4K = 6'd12;

    // Page-pair halves are picked by these VA bits
    localparam int HUGE_ODD_BIT  = 21;
    localparam int SMALL_ODD_BIT = 12;

    localparam logic [1:0] MAT_CACHED = 2'd1;

    typedef logic [VA_W-1:0]   vaddr_t;
    typedef logic [VPPN_W-1:0] vppn_t;
    typedef logic [PPN_W-1:0]  ppn_t;
    typedef logic [ASID_W-1:0] asid_t;
    typedef logic [IDX_W-1:0]  tlb_idx_t;

    typedef struct packed {
        logic       v;
        logic       d;
        logic [1:0] mat;
        logic [1:0] plv;
        ppn_t       ppn;
    } tlb_page_t;

    typedef struct packed {
        logic            e;
        asid_t           asid;
        logic            g;
        logic [PS_W-1:0] ps;
        vppn_t           vppn;
        tlb_page_t       even;
        tlb_page_t       odd;
    } tlb_entry_t;

    typedef struct packed {
        logic       en;
        logic [2:0] vseg;
        logic [2:0] pseg;
        logic       cached;
    } dmw_t;

    // CSR fields the TLB looks at
    typedef struct packed {
        logic     pg;
        asid_t    asid;
        dmw_t     dmw0;
        dmw_t     dmw1;
        logic     da_cached_fetch;
        logic     da_cached_data;
        vppn_t    srch_vppn;
        tlb_idx_t wr_index;
    } csr_view_t;

    typedef struct packed {
        logic   valid;
        vaddr_t va;
    } xlate_req_t;

    typedef struct packed {
        logic       valid;
        vaddr_t     pa;
        logic       cached;
        logic       mapped;
        logic       hit;
        logic       page_valid;
        logic       dirty;
        logic [1:0] plv;
    } xlate_rsp_t;

    typedef enum logic [4:0] {
        INV_ALL0       = 5'd0,
        INV_ALL1       = 5'd1,
        INV_GLOBAL     = 5'd2,
        INV_NONGLOBAL  = 5'd3,
        INV_ASID       = 5'd4,
        INV_ASID_VA    = 5'd5,
        INV_GORASID_VA = 5'd6
    } inv_op_t;

endpackage

// File: rtl/tlb_search_unit.sv
module tlb_search_unit (
    input  logic                                       clk,
    input  logic                                       rstn,
    input  logic                                       srch_strobe,
    input  tlb_pkg::asid_t                             asid,
    input  tlb_pkg::vppn_t                             vppn,
    input  tlb_pkg::tlb_entry_t [tlb_pkg::TLB_NUM-1:0] entries,
    output logic                                       srch_done,
    output logic                                       srch_hit,
    output tlb_pkg::tlb_idx_t                          srch_index
);

    logic [tlb_pkg::TLB_NUM-1:0] match;
    logic                        enc_hit;
    tlb_pkg::tlb_idx_t           enc_index;

    // Full VPPN compare regardless of page size
    for (genvar i = 0; i < tlb_pkg::TLB_NUM; i++) begin : g_match
        assign match[i] = entries[i].e
                       && (entries[i].g || (entries[i].asid == asid))
                       && (entries[i].vppn == vppn);
    end

    always_comb begin
        enc_hit   = 1'b0;
        enc_index = '0;
        for (int i = tlb_pkg::TLB_NUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                enc_hit   = 1'b1;
                enc_index = tlb_pkg::tlb_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            srch_done  <= 1'b0;
            srch_hit   <= 1'b0;
            srch_index <= '0;
        end else begin
            srch_done <= srch_strobe;
            if (srch_strobe) begin
                srch_hit   <= enc_hit;
                srch_index <= enc_index;
            end
        end
    end

endmodule

// File: rtl/tlb_top.sv
module tlb_top (
    input  logic                 clk,
    input  logic                 rstn,

    input  tlb_pkg::csr_view_t   csr,
    input  logic                 flush,

    input  tlb_pkg::xlate_req_t  fetch_req,
    input  logic                 fetch_stall,
    output tlb_pkg::xlate_rsp_t  fetch_rsp,

    input  tlb_pkg::xlate_req_t  data_req,
    input  logic                 data_stall,
    output tlb_pkg::xlate_rsp_t  data_rsp,

    input  logic                 wr_strobe,
    input  tlb_pkg::tlb_entry_t  wr_entry,

    input  logic                 rd_strobe,
    input  tlb_pkg::tlb_idx_t    rd_index,
    output logic                 rd_done,
    output logic                 rd_hit,
    output tlb_pkg::tlb_entry_t  rd_entry,

    input  logic                 srch_strobe,
    output logic                 srch_done,
    output logic                 srch_hit,
    output tlb_pkg::tlb_idx_t    srch_index,

    input  logic                 inv_strobe,
    input  tlb_pkg::inv_op_t     inv_op,
    input  tlb_pkg::asid_t       inv_asid,
    input  tlb_pkg::vppn_t       inv_vppn
);

    tlb_pkg::tlb_entry_t [tlb_pkg::TLB_NUM-1:0] entries;

    tlb_entry_array i_entries (
        .clk        (clk),
        .rstn       (rstn),
        .wr_strobe  (wr_strobe),
        .wr_index   (csr.wr_index),
        .wr_entry   (wr_entry),
        .inv_strobe (inv_strobe),
        .inv_op     (inv_op),
        .inv_asid   (inv_asid),
        .inv_vppn   (inv_vppn),
        .rd_strobe  (rd_strobe),
        .rd_index   (rd_index),
        .rd_done    (rd_done),
        .rd_hit     (rd_hit),
        .rd_entry   (rd_entry),
        .entries    (entries)
    );

    tlb_lookup_lane i_fetch_lane (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .stall     (fetch_stall),
        .req       (fetch_req),
        .csr       (csr),
        .da_cached (csr.da_cached_fetch),
        .entries   (entries),
        .rsp       (fetch_rsp)
    );

    tlb_lookup_lane i_data_lane (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .stall     (data_stall),
        .req       (data_req),
        .csr       (csr),
        .da_cached (csr.da_cached_data),
        .entries   (entries),
        .rsp       (data_rsp)
    );

    tlb_search_unit i_search (
        .clk         (clk),
        .rstn        (rstn),
        .srch_strobe (srch_strobe),
        .asid        (csr.asid),
        .vppn        (csr.srch_vppn),
        .entries     (entries),
        .srch_done   (srch_done),
        .srch_hit    (srch_hit),
        .srch_index  (srch_index)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_tlb -f tlb.f -o tb_tlb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_tlb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Test OK$"; then
    exit 0
fi
exit 1

// File: tlb.f
+incdir+include
rtl/tlb_pkg.sv
rtl/tlb_entry_array.sv
rtl/tlb_lookup_lane.sv
rtl/tlb_search_unit.sv
rtl/tlb_top.sv
bench/tb_tlb.sv
